//--- hdl/fetch_pkg.sv
// Fetch front end definitions
`default_nettype none

package fetch_pkg;

  // Machine word for addresses and instructions
  typedef logic [31:0] word_t;

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0200;

  // Branch target buffer geometry
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);   // Index taken from PC[5:2]
  localparam int BTB_TAG_W   = 32 - BTB_IDX_W - 2;    // Remaining upper PC bits

  // Byte order used on the instruction bus
  typedef enum logic {
    BIG_ENDIAN,
    LITTLE_ENDIAN
  } bus_endian_t;

  // The memory holds each word as little endian bytes
  localparam bus_endian_t BUS_ENDIANNESS = LITTLE_ENDIAN;

endpackage

`default_nettype wire

//--- hdl/branch_target_buffer.sv
// Branch target buffer
`timescale 1ns/100ps
`default_nettype none

module branch_target_buffer (
  input  logic             CLK,
  input  logic             nRST,
  input  fetch_pkg::word_t lookup_pc,       // PC being fetched this cycle
  output logic             hit,             // Indexed entry matches the PC
  output fetch_pkg::word_t target,          // Predicted target of that entry
  input  logic             update_valid,    // Install request from execute
  input  fetch_pkg::word_t update_pc,       // Branch address to install
  input  fetch_pkg::word_t update_target    // Taken target of that branch
);
  import fetch_pkg::*;

  // One valid bit per entry so that reset empties the table
  logic [BTB_ENTRIES-1:0] valid_q;

  // Tag and target storage for each entry
  logic [BTB_TAG_W-1:0] tag_q    [BTB_ENTRIES];
  word_t                target_q [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0] lookup_idx;
  logic [BTB_TAG_W-1:0] lookup_tag;
  logic [BTB_IDX_W-1:0] update_idx;
  logic [BTB_TAG_W-1:0] update_tag;

  // Word address bits pick the entry and the rest of the PC is the tag
  assign lookup_idx = lookup_pc[BTB_IDX_W+1:2];
  assign lookup_tag = lookup_pc[31:BTB_IDX_W+2];
  assign update_idx = update_pc[BTB_IDX_W+1:2];
  assign update_tag = update_pc[31:BTB_IDX_W+2];

  // Lookup is purely combinational on the current PC
  assign hit    = valid_q[lookup_idx] & (tag_q[lookup_idx] == lookup_tag);
  assign target = target_q[lookup_idx];   // Only meaningful when hit is high

  // An update marks its entry as holding a branch
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (update_valid) begin
      valid_q[update_idx] <= 1'b1;   // Entry becomes visible on the next cycle
    end
  end

  // An update simply replaces whatever sits in the indexed entry
  always_ff @(posedge CLK) begin
    if (update_valid) begin
      tag_q[update_idx]    <= update_tag;
      target_q[update_idx] <= update_target;
    end
  end

endmodule

`default_nettype wire

//--- hdl/pc_generator.sv
// Fetch1 program counter stage
`timescale 1ns/100ps
`default_nettype none

module pc_generator (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             pc_en,               // Fetch1 slot moves on to fetch2
  input  logic             flush,               // Drop the slot and restart on the new path
  input  logic             redirect_valid,      // One cycle redirect pulse from execute
  input  fetch_pkg::word_t redirect_pc,
  input  logic             btb_update_valid,
  input  fetch_pkg::word_t btb_update_pc,
  input  fetch_pkg::word_t btb_update_target,
  output logic             f1_valid,            // Slot toward fetch2 holds an instruction
  output fetch_pkg::word_t f1_pc,
  output logic             f1_prediction        // BTB predicted this PC taken
);
  import fetch_pkg::*;

  word_t pc_q;           // Address of the next instruction to fetch
  word_t pc4;
  word_t next_pc;
  word_t redir_pc_q;     // Redirect target kept until the flush arrives
  word_t redir_tgt;
  logic  redir_pend_q;
  logic  redir_pend;
  logic  btb_hit;
  word_t btb_target;

  // Prediction lookup on the PC that is about to enter the slot
  branch_target_buffer u_btb (
    .CLK           (CLK),
    .nRST          (nRST),
    .lookup_pc     (pc_q),
    .hit           (btb_hit),
    .target        (btb_target),
    .update_valid  (btb_update_valid),
    .update_pc     (btb_update_pc),
    .update_target (btb_update_target)
  );

  assign pc4        = pc_q + 32'd4;
  assign redir_pend = redirect_valid | redir_pend_q;   // A fresh pulse counts at once
  assign redir_tgt  = redirect_valid ? redirect_pc : redir_pc_q;

  // Redirect first, then a predicted taken branch, then the sequential path
  always_comb begin
    if (redir_pend) begin
      next_pc = redir_tgt;
    end else if (btb_hit) begin
      next_pc = btb_target;
    end else begin
      next_pc = pc4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q         <= RESET_PC;
      f1_valid     <= 1'b0;
      redir_pend_q <= 1'b0;
    end else if (flush) begin
      pc_q         <= redir_tgt;   // Whatever advanced meanwhile was on the old path
      f1_valid     <= 1'b0;
      redir_pend_q <= 1'b0;
    end else begin
      if (redirect_valid) begin
        redir_pend_q <= 1'b1;      // Held while fetch2 finishes an outstanding read
      end
      if (pc_en) begin
        pc_q     <= next_pc;
        f1_valid <= 1'b1;          // Slot is refilled every time it is taken
      end
    end
  end

  // Slot payload and redirect target
  always_ff @(posedge CLK) begin
    if (redirect_valid) begin
      redir_pc_q <= redirect_pc;
    end
    if (pc_en) begin
      f1_pc         <= pc_q;
      f1_prediction <= btb_hit;
    end
  end

endmodule

`default_nettype wire

//--- hdl/instr_fetch_stage.sv
// Fetch2 instruction read stage
`timescale 1ns/100ps
`default_nettype none

module instr_fetch_stage (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             halt,
  input  logic             f1_valid,
  input  fetch_pkg::word_t f1_pc,
  input  logic             f1_prediction,
  input  logic             flush,
  input  logic             stall,            // Output register is full and not taken
  output logic             f2_accept,        // Fetch1 slot may move in this cycle
  output logic             i_mem_busy,       // Bus read still in progress
  output logic             imem_ren,
  output fetch_pkg::word_t imem_addr,
  input  logic             imem_busy,
  input  fetch_pkg::word_t imem_rdata,
  output logic             dec_valid,
  output fetch_pkg::word_t dec_pc,
  output fetch_pkg::word_t dec_pc4,
  output fetch_pkg::word_t dec_instr,
  output logic             dec_prediction,
  output logic             dec_mal_insn
);
  import fetch_pkg::*;

  // Slot occupancy of this stage
  typedef enum logic [1:0] {
    SLOT_EMPTY,
    SLOT_READING,    // Aligned PC waiting for its word
    SLOT_HOLDING     // Word captured or misaligned PC with nothing to read
  } slot_state_t;

  slot_state_t state_q;
  word_t       slot_pc_q;
  logic        slot_pred_q;
  logic        slot_mal_q;
  word_t       hold_word_q;     // Word kept while decode or halt blocks the output
  logic        req_active_q;    // Bus has seen the request and not yet answered
  logic        dec_valid_q;
  word_t       bus_word;
  word_t       item_word;
  word_t       pc4;
  logic        f1_mal;
  logic        take;
  logic        rd_done;
  logic        item_ready;
  logic        out_load;

  assign f1_mal = (f1_pc[1:0] != 2'b00);   // Misaligned PCs never touch the bus
  assign pc4    = slot_pc_q + 32'd4;

  // A started read runs to completion even when halt rises
  assign imem_ren   = (state_q == SLOT_READING) & (~halt | req_active_q);
  assign imem_addr  = slot_pc_q;
  assign i_mem_busy = imem_ren & imem_busy;
  assign rd_done    = imem_ren & ~imem_busy;   // First cycle with busy low ends the read

  assign item_ready = rd_done | (state_q == SLOT_HOLDING);
  assign item_word  = (state_q == SLOT_HOLDING) ? hold_word_q : bus_word;
  assign out_load   = item_ready & ~stall & ~halt;

  // Slot frees up when empty or when its item moves to the output register
  assign f2_accept = ((state_q == SLOT_EMPTY) | out_load) & ~halt;
  assign take      = f2_accept & f1_valid;

  assign dec_valid = dec_valid_q & ~halt;   // Held item reappears once halt drops

  // Swap bytes when the bus delivers little endian words
  generate
    if (BUS_ENDIANNESS == LITTLE_ENDIAN) begin : g_swap
      assign bus_word = {imem_rdata[7:0], imem_rdata[15:8],
                         imem_rdata[23:16], imem_rdata[31:24]};
    end else begin : g_direct
      assign bus_word = imem_rdata;
    end
  endgenerate

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_q      <= SLOT_EMPTY;
      req_active_q <= 1'b0;
      dec_valid_q  <= 1'b0;
    end else if (flush) begin
      state_q      <= SLOT_EMPTY;   // Flush only comes with no read outstanding
      req_active_q <= 1'b0;
      dec_valid_q  <= 1'b0;         // Unaccepted instruction is dropped
    end else begin
      req_active_q <= i_mem_busy;
      if (take) begin
        state_q <= f1_mal ? SLOT_HOLDING : SLOT_READING;
      end else if (out_load) begin
        state_q <= SLOT_EMPTY;
      end else if (rd_done) begin
        state_q <= SLOT_HOLDING;    // Decode or halt is blocking
      end
      if (out_load) begin
        dec_valid_q <= 1'b1;
      end else if (dec_valid & ~stall) begin
        dec_valid_q <= 1'b0;        // Decode took it this cycle
      end
    end
  end

  // Slot and output payload
  always_ff @(posedge CLK) begin
    if (take) begin
      slot_pc_q   <= f1_pc;
      slot_pred_q <= f1_prediction;
      slot_mal_q  <= f1_mal;
    end
    if (take & f1_mal) begin
      hold_word_q <= '0;            // Misaligned item carries a zero word
    end else if (rd_done & ~out_load) begin
      hold_word_q <= bus_word;
    end
    if (out_load) begin
      dec_pc         <= slot_pc_q;
      dec_pc4        <= pc4;
      dec_instr      <= item_word;
      dec_prediction <= slot_pred_q;
      dec_mal_insn   <= slot_mal_q;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_control.sv
// Fetch hazard control
`timescale 1ns/100ps
`default_nettype none

module fetch_control (
  input  logic CLK,
  input  logic nRST,
  input  logic halt,
  input  logic redirect_valid,   // One cycle pulse from execute
  input  logic i_mem_busy,       // Fetch2 has a read in progress
  input  logic f2_accept,        // Fetch2 can take the fetch1 slot
  input  logic dec_valid,
  input  logic dec_ready,
  output logic pc_en,            // Advance fetch1
  output logic flush,            // Empty both slots and the output register
  output logic stall             // Hold the output register
);

  logic redir_q;      // Redirect seen but flush still waiting on the bus
  logic redir_pend;

  // Output register is stuck while decode refuses it
  assign stall = dec_valid & ~dec_ready;

  // Fetch1 only moves when fetch2 takes its slot and fetching is allowed
  assign pc_en = f2_accept & ~halt;

  // A new pulse or a latched one both ask for a flush
  assign redir_pend = redirect_valid | redir_q;

  // Flush waits until no bus read is in flight so the protocol stays intact
  assign flush = redir_pend & ~i_mem_busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      redir_q <= 1'b0;
    end else if (flush) begin
      redir_q <= 1'b0;   // Flush is a single cycle
    end else if (redirect_valid) begin
      redir_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_frontend.sv
// Instruction fetch front end
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             halt,
  // Decode side
  output logic             dec_valid,
  input  logic             dec_ready,
  output fetch_pkg::word_t dec_pc,
  output fetch_pkg::word_t dec_pc4,
  output fetch_pkg::word_t dec_instr,
  output logic             dec_prediction,
  output logic             dec_mal_insn,
  // Instruction bus
  output logic             imem_ren,
  output fetch_pkg::word_t imem_addr,
  input  logic             imem_busy,
  input  fetch_pkg::word_t imem_rdata,
  // Execute feedback
  input  logic             redirect_valid,
  input  fetch_pkg::word_t redirect_pc,
  input  logic             btb_update_valid,
  input  fetch_pkg::word_t btb_update_pc,
  input  fetch_pkg::word_t btb_update_target
);
  import fetch_pkg::*;

  logic  f1_valid;
  word_t f1_pc;
  logic  f1_prediction;
  logic  i_mem_busy;
  logic  f2_accept;
  logic  pc_en;
  logic  flush;
  logic  stall;

  // Fetch1 with the PC and the BTB
  pc_generator u_pc_gen (
    .CLK               (CLK),
    .nRST              (nRST),
    .pc_en             (pc_en),
    .flush             (flush),
    .redirect_valid    (redirect_valid),
    .redirect_pc       (redirect_pc),
    .btb_update_valid  (btb_update_valid),
    .btb_update_pc     (btb_update_pc),
    .btb_update_target (btb_update_target),
    .f1_valid          (f1_valid),
    .f1_pc             (f1_pc),
    .f1_prediction     (f1_prediction)
  );

  // Fetch2 with the bus access and the register toward decode
  instr_fetch_stage u_fetch2 (
    .CLK            (CLK),
    .nRST           (nRST),
    .halt           (halt),
    .f1_valid       (f1_valid),
    .f1_pc          (f1_pc),
    .f1_prediction  (f1_prediction),
    .flush          (flush),
    .stall          (stall),
    .f2_accept      (f2_accept),
    .i_mem_busy     (i_mem_busy),
    .imem_ren       (imem_ren),
    .imem_addr      (imem_addr),
    .imem_busy      (imem_busy),
    .imem_rdata     (imem_rdata),
    .dec_valid      (dec_valid),
    .dec_pc         (dec_pc),
    .dec_pc4        (dec_pc4),
    .dec_instr      (dec_instr),
    .dec_prediction (dec_prediction),
    .dec_mal_insn   (dec_mal_insn)
  );

  // Stall, advance and flush decisions
  fetch_control u_ctrl (
    .CLK            (CLK),
    .nRST           (nRST),
    .halt           (halt),
    .redirect_valid (redirect_valid),
    .i_mem_busy     (i_mem_busy),
    .f2_accept      (f2_accept),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .pc_en          (pc_en),
    .flush          (flush),
    .stall          (stall)
  );

endmodule

`default_nettype wire

//--- bench/imem_model.sv
// Behavioral instruction memory
`timescale 1ns/100ps
`default_nettype none

module imem_model (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             ren,
  input  fetch_pkg::word_t addr,
  input  logic [1:0]       wait_sel,    // Wait states for a read that starts this cycle
  output logic             busy,
  output fetch_pkg::word_t rdata,
  output logic             proto_err    // Read dropped or address moved while busy
);
  import fetch_pkg::*;

  logic       active_q;   // Previous cycle was a busy cycle of the same read
  logic [1:0] left_q;     // Busy cycles still owed after the first one
  word_t      addr_q;
  word_t      word_le;

  // Each word holds its little endian bytes with the lowest address in [7:0]
  assign word_le = addr ^ 32'h5a5a_0000;

  // A read with no wait states completes in the cycle it starts
  assign busy  = ren & (active_q ? (left_q != 2'd0) : (wait_sel != 2'd0));
  assign rdata = (ren & ~busy) ? word_le : 'x;   // Undefined outside the valid cycle

  // Once busy has been seen the request must stay up on the same address
  assign proto_err = active_q & (~ren | (addr != addr_q));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active_q <= 1'b0;
      left_q   <= 2'd0;
      addr_q   <= '0;
    end else if (busy) begin
      active_q <= 1'b1;
      left_q   <= active_q ? left_q - 2'd1 : wait_sel - 2'd1;
      addr_q   <= addr;
    end else begin
      active_q <= 1'b0;   // Read finished or none requested
    end
  end

endmodule

`default_nettype wire

//--- bench/fetch_frontend_tb.sv
// Fetch front end testbench
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend_tb;
  import fetch_pkg::*;

  localparam int TOTAL_XFERS = 186;                   // Sum of the transfers of all tests
  localparam int CYCLE_LIMIT = 6 * TOTAL_XFERS * 5;

  logic  CLK, nRST, halt, dec_valid, dec_ready, dec_prediction, dec_mal_insn;
  word_t dec_pc, dec_pc4, dec_instr, imem_addr, imem_rdata, redirect_pc;
  logic  imem_ren, imem_busy, redirect_valid, btb_update_valid, proto_err;
  word_t btb_update_pc, btb_update_target;
  logic [1:0] wait_sel;

  logic random_on;                 // Random ready and wait states
  int   error_count, check_count, xfer_count, cycle_count, test_errs;
  word_t exp_pc;                   // Next PC the decode side should accept
  logic  pred_seen, prev_stalled;
  word_t prev_pc, prev_instr;
  word_t prev_pc4;
  logic  prev_pred, prev_mal;
  logic                 btb_valid_m  [BTB_ENTRIES];   // Model of the BTB contents
  logic [BTB_TAG_W-1:0] btb_tag_m    [BTB_ENTRIES];
  word_t                btb_target_m [BTB_ENTRIES];

  fetch_frontend UUT (.*);

  imem_model u_imem (.CLK(CLK), .nRST(nRST), .ren(imem_ren), .addr(imem_addr),
    .wait_sel(wait_sel), .busy(imem_busy), .rdata(imem_rdata), .proto_err(proto_err));

  // Byte reversed memory word, and zero when the PC is misaligned
  function automatic word_t expected_instr(input word_t pc);
    word_t w;
    w = pc ^ 32'h5a5a_0000;
    if (pc[1:0] != 2'b00) return '0;
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic model_hit(input word_t pc);
    logic [BTB_IDX_W-1:0] idx;
    idx = pc[BTB_IDX_W+1:2];
    return btb_valid_m[idx] && (btb_tag_m[idx] == pc[31:BTB_IDX_W+2]);
  endfunction

  function automatic word_t next_pc(input word_t pc);
    return model_hit(pc) ? btb_target_m[pc[BTB_IDX_W+1:2]] : pc + 32'd4;  // Taken or sequential
  endfunction

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Advance one clock and redraw the random inputs
  task automatic tick();
    logic [31:0] r_wait;
    logic [31:0] r_ready;
    @(posedge CLK);
    r_wait  = random_on ? $urandom : 32'd0;
    r_ready = random_on ? $urandom : 32'd9;
    wait_sel  <= r_wait[1:0];
    dec_ready <= (r_ready % 10) >= 3;   // Low about 30 % of the time
  endtask

  task automatic run_transfers(input int n);
    int target;
    target = xfer_count + n;
    while (xfer_count < target) tick();
  endtask

  // Decode is held off until the flush, which waits out any busy bus read
  task automatic redirect_to(input word_t target);
    redirect_valid <= 1'b1;
    redirect_pc    <= target;
    dec_ready      <= 1'b0;
    tick();
    redirect_valid   <= 1'b0;
    btb_update_valid <= 1'b0;
    dec_ready        <= 1'b0;
    while (imem_ren & imem_busy) begin
      tick();
      dec_ready <= 1'b0;
    end
  endtask

  task automatic report_test(input string name);
    $display("Test %s done with %0d errors", name, error_count - test_errs);
    test_errs = error_count;
  endtask

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Compares every accepted transfer with the model stream
  always @(posedge CLK) begin
    if (nRST) begin
      check_bit("misaligned_read", 1'b0, imem_ren & (imem_addr[1:0] != 2'b00));
      check_bit("bus_protocol", 1'b0, proto_err);
      if (prev_stalled && dec_valid) begin
        check_word("held_dec_pc", prev_pc, dec_pc);
        check_word("held_dec_pc4", prev_pc4, dec_pc4);
        check_word("held_dec_instr", prev_instr, dec_instr);
        check_bit("held_dec_prediction", prev_pred, dec_prediction);
        check_bit("held_dec_mal_insn", prev_mal, dec_mal_insn);
      end
      if (dec_valid && dec_ready) begin
        check_word("dec_pc", exp_pc, dec_pc);
        check_word("dec_pc4", exp_pc + 32'd4, dec_pc4);
        check_word("dec_instr", expected_instr(exp_pc), dec_instr);
        check_bit("dec_prediction", model_hit(exp_pc), dec_prediction);
        check_bit("dec_mal_insn", exp_pc[1:0] != 2'b00, dec_mal_insn);
        pred_seen  = pred_seen | dec_prediction;
        exp_pc     = next_pc(exp_pc);
        xfer_count <= xfer_count + 1;
      end
      if (btb_update_valid) begin
        btb_valid_m[btb_update_pc[BTB_IDX_W+1:2]]  = 1'b1;
        btb_tag_m[btb_update_pc[BTB_IDX_W+1:2]]    = btb_update_pc[31:BTB_IDX_W+2];
        btb_target_m[btb_update_pc[BTB_IDX_W+1:2]] = btb_update_target;
      end
      if (redirect_valid) exp_pc = redirect_pc;   // Old path is gone from here on
      prev_stalled = dec_valid & ~dec_ready;
      prev_pc      = dec_pc;
      prev_pc4     = dec_pc4;
      prev_instr   = dec_instr;
      prev_pred    = dec_prediction;
      prev_mal     = dec_mal_insn;
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout after %0d cycles with %0d transfers seen", cycle_count, xfer_count);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int seed_val;
    seed_val = 32'haf81;
    seed_val = $urandom(seed_val);
    {nRST, halt, redirect_valid, btb_update_valid, random_on, pred_seen} = '0;
    {redirect_pc, btb_update_pc, btb_update_target} = '0;
    dec_ready    = 1'b1;
    wait_sel     = 2'd0;
    prev_stalled = 1'b0;
    {error_count, check_count, xfer_count, test_errs} = '0;
    exp_pc = RESET_PC;
    for (int i = 0; i < BTB_ENTRIES; i++) btb_valid_m[i] = 1'b0;
    repeat (2) @(posedge CLK);
    nRST <= 1'b1;
    run_transfers(40);
    report_test("sequential");
    random_on = 1'b1;
    run_transfers(60);
    report_test("backpressure");
    redirect_to(32'h0000_0800);
    run_transfers(30);
    report_test("redirect");
    pred_seen = 1'b0;
    btb_update_valid  <= 1'b1;   // Branch at 0x1010 goes to 0x1800
    btb_update_pc     <= 32'h0000_1010;
    btb_update_target <= 32'h0000_1800;
    redirect_to(32'h0000_1000);
    run_transfers(20);
    check_bit("btb_prediction_seen", 1'b1, pred_seen);
    report_test("btb");
    redirect_to(32'h0000_3002);
    run_transfers(6);
    report_test("misaligned");
    redirect_to(32'h0000_4000);
    run_transfers(10);
    halt <= 1'b1;
    tick();
    while (imem_ren & imem_busy) tick();   // Outstanding read may finish
    repeat (4) begin
      tick();
      check_bit("halt_imem_ren", 1'b0, imem_ren);
      check_bit("halt_dec_valid", 1'b0, dec_valid);
    end
    halt <= 1'b0;
    run_transfers(20);
    report_test("halt");
    $display("Checks %0d, errors %0d, transfers %0d", check_count, error_count, xfer_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hdl/fetch_pkg.sv
hdl/branch_target_buffer.sv
hdl/pc_generator.sv
hdl/instr_fetch_stage.sv
hdl/fetch_control.sv
hdl/fetch_frontend.sv
bench/imem_model.sv
bench/fetch_frontend_tb.sv
